/* mips_config.svh */
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

// first fetch address after reset
`define RESET_PC 32'h0000_0000

// architectural registers, r0 hardwired to zero
`define REG_COUNT 32

// word-address widths of the two memory ports
`define IMEM_AW 10
`define DMEM_AW 10

`endif

/* mipsPkg.sv */
package mipsPkg;

    // register-format layout
    typedef struct packed {
        logic [5:0] op;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;      // selects the operation when op is zero
    } rFields;

    // immediate-format layout, also used for the jump target
    typedef struct packed {
        logic [5:0]  op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } iFields;

    // one instruction word, two ways to read it
    typedef union packed {
        rFields r;
        iFields i;
    } instrWord;

endpackage

/* execBus.sv */
`timescale 1ns/1ps

interface execBus;
    import mipsPkg::*;

    logic [31:0] readData1;     // rs value
    logic [31:0] readData2;     // rt value
    logic [31:0] signExtend;    // sign or zero extended immediate
    instrWord    instr;
    logic [1:0]  aluOp;         // {r or i alu op, branch compare}
    logic        aluSrc;        // immediate as second operand
    logic        iFormat;       // immediate alu instructions
    logic        sftmd;         // shift instruction
    logic        jr;
    logic [31:0] pcPlus4;
    logic [31:0] aluResult;
    logic        zero;          // rs equals rt
    logic [31:0] addrResult;    // branch target

    modport dec (
        output readData1, readData2, signExtend, instr, aluOp, aluSrc,
        output iFormat, sftmd, jr, pcPlus4,
        input  aluResult
    );

    modport alu (
        input  readData1, readData2, signExtend, instr, aluOp, aluSrc,
        input  iFormat, sftmd, pcPlus4,
        output aluResult, zero, addrResult
    );

endinterface

/* fetchUnit.sv */
`timescale 1ns/1ps
`include "mips_config.svh"

module fetchUnit (
    input  logic                clock,
    input  logic                rstN,
    input  logic                stall,
    input  logic                branch,
    input  logic                nBranch,
    input  logic                jmp,
    input  logic                jr,
    input  logic                zero,
    input  logic [31:0]         addrResult,
    input  logic [25:0]         jumpTarget,
    input  logic [31:0]         regTarget,
    output logic [`IMEM_AW-1:0] instrAddr,
    output logic [31:0]         pcPlus4
);

    logic [31:0] pc;            // byte address
    logic [31:0] nextPc;
    logic        taken;

    assign pcPlus4   = pc + 32'd4;
    assign instrAddr = pc[`IMEM_AW+1:2];     // word index into imem
    assign taken     = (branch && zero) || (nBranch && !zero);

    always_comb begin
        if (jr) begin
            nextPc = regTarget;
        end else if (jmp) begin
            nextPc = {pcPlus4[31:28], jumpTarget, 2'b00};     // region of next instr
        end else if (taken) begin
            nextPc = addrResult;
        end else begin
            nextPc = pcPlus4;
        end
    end

    always_ff @(posedge clock) begin
        if (!rstN) begin
            pc <= `RESET_PC;
        end else if (!stall) begin      // hold during data access
            pc <= nextPc;
        end
    end

endmodule

/* decodeUnit.sv */
`timescale 1ns/1ps
`include "mips_config.svh"

module decodeUnit (
    input  logic              clock,
    input  logic              rstN,
    input  logic              stall,
    input  mipsPkg::instrWord instrData,
    input  logic [31:0]       pcPlus4,
    input  logic [31:0]       loadData,
    execBus.dec               bus,
    output logic              branch,
    output logic              nBranch,
    output logic              jmp,
    output logic              jal,
    output logic              memRead,
    output logic              memWrite
);

    localparam logic [5:0] opRtype  = 6'h00;
    localparam logic [5:0] opJ      = 6'h02;
    localparam logic [5:0] opJal    = 6'h03;
    localparam logic [5:0] opBeq    = 6'h04;
    localparam logic [5:0] opBne    = 6'h05;
    localparam logic [5:0] opAndi   = 6'h0C;
    localparam logic [5:0] opOri    = 6'h0D;
    localparam logic [5:0] opXori   = 6'h0E;
    localparam logic [5:0] opLw     = 6'h23;
    localparam logic [5:0] opSw     = 6'h2B;
    localparam logic [5:0] functJr  = 6'h08;

    logic [31:0] regFile [`REG_COUNT];
    logic        rFormat;
    logic        zeroExt;
    logic        regWrite;
    logic [4:0]  writeReg;
    logic [31:0] writeData;
    logic [15:0] imm;

    assign imm = instrData.i.imm;

    // main control
    assign rFormat  = instrData.r.op == opRtype;
    assign branch   = instrData.i.op == opBeq;
    assign nBranch  = instrData.i.op == opBne;
    assign jal      = instrData.i.op == opJal;
    assign jmp      = (instrData.i.op == opJ) || jal;     // jal jumps too
    assign memRead  = instrData.i.op == opLw;
    assign memWrite = instrData.i.op == opSw;

    assign bus.jr      = rFormat && (instrData.r.funct == functJr);
    assign bus.iFormat = instrData.i.op[5:3] == 3'b001;  // addi .. lui
    assign bus.aluSrc  = bus.iFormat || memRead || memWrite;
    assign bus.aluOp   = {rFormat || bus.iFormat, branch || nBranch};
    assign bus.sftmd   = rFormat && (instrData.r.funct[5:3] == 3'b000);

    // operands
    assign bus.readData1 = (instrData.r.rs == 5'd0) ? 32'd0 : regFile[instrData.r.rs];
    assign bus.readData2 = (instrData.r.rt == 5'd0) ? 32'd0 : regFile[instrData.r.rt];

    assign zeroExt = (instrData.i.op == opAndi) || (instrData.i.op == opOri)
                  || (instrData.i.op == opXori);
    assign bus.signExtend = zeroExt ? {16'h0000, imm} : {{16{imm[15]}}, imm};

    assign bus.instr   = instrData;
    assign bus.pcPlus4 = pcPlus4;

    // write-back
    assign regWrite = (rFormat && !bus.jr) || bus.iFormat || memRead || jal;

    always_comb begin
        if (jal) begin
            writeReg = 5'd31;       // link register
        end else if (rFormat) begin
            writeReg = instrData.r.rd;
        end else begin
            writeReg = instrData.r.rt;
        end
    end

    always_comb begin
        if (memRead) begin
            writeData = loadData;   // latched by memAccess
        end else if (jal) begin
            writeData = pcPlus4;
        end else begin
            writeData = bus.aluResult;
        end
    end

    always_ff @(posedge clock) begin
        if (!rstN) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regFile[i] <= 32'd0;
            end
        end else if (regWrite && !stall && (writeReg != 5'd0)) begin
            regFile[writeReg] <= writeData;
        end
    end

endmodule

/* aluUnit.sv */
`timescale 1ns/1ps

module aluUnit (
    execBus.alu bus
);

    logic [31:0] aInput;
    logic [31:0] bInput;
    logic [5:0]  exeCode;
    logic [2:0]  aluCtl;
    logic [31:0] aluOutput;
    logic [4:0]  shiftAmt;
    logic [31:0] shiftResult;
    logic        rFormat;
    logic        setSigned;
    logic        setUnsigned;
    logic        luiOp;

    assign aInput  = bus.readData1;
    assign bInput  = bus.aluSrc ? bus.signExtend : bus.readData2;
    assign rFormat = bus.aluOp[1] && !bus.iFormat;

    // immediate ops reuse the funct encoding through the low opcode bits
    assign exeCode = bus.iFormat ? {3'b000, bus.instr.i.op[2:0]} : bus.instr.r.funct;

    assign aluCtl[0] = (exeCode[0] | exeCode[3]) & bus.aluOp[1];
    assign aluCtl[1] = ~exeCode[2] | ~bus.aluOp[1];
    assign aluCtl[2] = (exeCode[1] & bus.aluOp[1]) | bus.aluOp[0];

    always_comb begin
        case (aluCtl)
            3'b000:         aluOutput = aInput & bInput;
            3'b001:         aluOutput = aInput | bInput;
            3'b010, 3'b011: aluOutput = aInput + bInput;      // add and addu, no overflow trap
            3'b100:         aluOutput = aInput ^ bInput;
            3'b101:         aluOutput = ~(aInput | bInput);
            default:        aluOutput = aInput - bInput;      // sub and subu
        endcase
    end

    // variable shifts take the amount from rs
    assign shiftAmt = bus.instr.r.funct[2] ? aInput[4:0] : bus.instr.r.shamt;

    always_comb begin
        case (bus.instr.r.funct[1:0])
            2'b00:   shiftResult = bInput << shiftAmt;
            2'b10:   shiftResult = bInput >> shiftAmt;
            2'b11:   shiftResult = $signed(bInput) >>> shiftAmt;    // sign fill
            default: shiftResult = bInput;
        endcase
    end

    assign setSigned   = (bus.iFormat && (bus.instr.i.op[2:0] == 3'b010))
                      || (rFormat && (bus.instr.r.funct == 6'b101010));
    assign setUnsigned = (bus.iFormat && (bus.instr.i.op[2:0] == 3'b011))
                      || (rFormat && (bus.instr.r.funct == 6'b101011));
    assign luiOp       = bus.iFormat && (aluCtl == 3'b101);

    always_comb begin
        if (setSigned) begin
            bus.aluResult = {31'd0, $signed(aInput) < $signed(bInput)};
        end else if (setUnsigned) begin
            bus.aluResult = {31'd0, aInput < bInput};
        end else if (luiOp) begin
            bus.aluResult = {bInput[15:0], 16'h0000};
        end else if (bus.sftmd) begin
            bus.aluResult = shiftResult;
        end else begin
            bus.aluResult = aluOutput;
        end
    end

    // branch compare uses the register operands regardless of aluSrc
    assign bus.zero       = (bus.readData1 - bus.readData2) == 32'd0;
    assign bus.addrResult = bus.pcPlus4 + {bus.signExtend[29:0], 2'b00};

endmodule

/* memAccess.sv */
`timescale 1ns/1ps
`include "mips_config.svh"

module memAccess (
    input  logic                clock,
    input  logic                rstN,
    input  logic                memRead,
    input  logic                memWrite,
    input  logic [31:0]         addr,
    input  logic [31:0]         storeData,
    output logic [31:0]         loadData,
    output logic                stall,
    output logic                wbCyc,
    output logic                wbStb,
    output logic                wbWe,
    output logic [`DMEM_AW-1:0] wbAdr,
    output logic [31:0]         wbDatW,
    input  logic [31:0]         wbDatR,
    input  logic                wbAck
);

    typedef enum logic {stIdle, stBusy} busState;

    busState state;
    logic    done;          // ack seen, instruction retires next edge
    logic    start;

    assign start = (state == stIdle) && !done && (memRead || memWrite);
    assign stall = (memRead || memWrite) && !done;
    assign wbCyc = state == stBusy;
    assign wbStb = state == stBusy;

    always_ff @(posedge clock) begin
        if (!rstN) begin
            state <= stIdle;
            done  <= 1'b0;
            wbWe  <= 1'b0;
        end else begin
            case (state)
                stIdle: begin
                    done <= 1'b0;
                    if (start) begin
                        state <= stBusy;
                        wbWe  <= memWrite;
                    end
                end
                default: begin
                    if (wbAck) begin    // drop cyc and stb on this edge
                        state <= stIdle;
                        done  <= 1'b1;
                        wbWe  <= 1'b0;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (start) begin
            wbAdr  <= addr[`DMEM_AW+1:2];
            wbDatW <= storeData;
        end
        if (wbCyc && wbAck) begin
            loadData <= wbDatR;
        end
    end

endmodule

/* mipsCore.sv */
`timescale 1ns/1ps
`include "mips_config.svh"

module mipsCore (
    input  logic                clock,
    input  logic                rstN,
    output logic [`IMEM_AW-1:0] instrAddr,
    input  logic [31:0]         instrData,
    output logic                wbCyc,
    output logic                wbStb,
    output logic                wbWe,
    output logic [`DMEM_AW-1:0] wbAdr,
    output logic [31:0]         wbDatW,
    input  logic [31:0]         wbDatR,
    input  logic                wbAck,
    output logic [3:0]          wbSel
);

    execBus bus ();

    logic [31:0] pcPlus4;
    logic [31:0] loadData;
    logic [31:0] aluResult;
    logic [31:0] addrResult;
    logic [31:0] regTarget;
    logic [31:0] storeData;
    logic [25:0] jumpTarget;
    logic        zero;
    logic        jr;
    logic        stall;
    logic        branch;
    logic        nBranch;
    logic        jmp;
    logic        memRead;
    logic        memWrite;

    assign aluResult  = bus.aluResult;     // data address for lw and sw
    assign addrResult = bus.addrResult;
    assign regTarget  = bus.readData1;     // jr target
    assign storeData  = bus.readData2;
    assign zero       = bus.zero;
    assign jr         = bus.jr;
    assign jumpTarget = {bus.instr.i.rs, bus.instr.i.rt, bus.instr.i.imm};
    assign wbSel      = 4'hF;              // word accesses only

    fetchUnit u_fetchUnit (
        .clock      (clock),
        .rstN       (rstN),
        .stall      (stall),
        .branch     (branch),
        .nBranch    (nBranch),
        .jmp        (jmp),
        .jr         (jr),
        .zero       (zero),
        .addrResult (addrResult),
        .jumpTarget (jumpTarget),
        .regTarget  (regTarget),
        .instrAddr  (instrAddr),
        .pcPlus4    (pcPlus4)
    );

    decodeUnit u_decodeUnit (
        .clock     (clock),
        .rstN      (rstN),
        .stall     (stall),
        .instrData (instrData),
        .pcPlus4   (pcPlus4),
        .loadData  (loadData),
        .bus       (bus.dec),
        .branch    (branch),
        .nBranch   (nBranch),
        .jmp       (jmp),
        .jal       (),
        .memRead   (memRead),
        .memWrite  (memWrite)
    );

    aluUnit u_aluUnit (
        .bus (bus.alu)
    );

    memAccess u_memAccess (
        .clock     (clock),
        .rstN      (rstN),
        .memRead   (memRead),
        .memWrite  (memWrite),
        .addr      (aluResult),
        .storeData (storeData),
        .loadData  (loadData),
        .stall     (stall),
        .wbCyc     (wbCyc),
        .wbStb     (wbStb),
        .wbWe      (wbWe),
        .wbAdr     (wbAdr),
        .wbDatW    (wbDatW),
        .wbDatR    (wbDatR),
        .wbAck     (wbAck)
    );

endmodule

/* mipsCore_sva.sv */
`timescale 1ns/1ps
`include "mips_config.svh"

module mipsCoreSva (
    input logic                clock,
    input logic                rstN,
    input logic [`IMEM_AW-1:0] instrAddr,
    input logic                wbCyc,
    input logic                wbStb,
    input logic                wbWe,
    input logic [`DMEM_AW-1:0] wbAdr,
    input logic [31:0]         wbDatW,
    input logic                wbAck
);

    localparam logic [31:0] resetPc = `RESET_PC;

    int unsigned failCount = 0;     // failures so far, watched by the testbench

    // cyc and stb end together on the edge after ack
    dropAfterAck: assert property (@(posedge clock) disable iff (!rstN)
        (wbCyc && wbAck) |=> (!wbCyc && !wbStb))
        else begin
            failCount++;
            $error("cyc or stb still high after ack");
        end

    // request must hold until acknowledged
    holdRequest: assert property (@(posedge clock) disable iff (!rstN)
        (wbStb && !wbAck) |=> ($stable(wbAdr) && $stable(wbWe) && $stable(wbDatW)))
        else begin
            failCount++;
            $error("request changed before ack");
        end

    afterReset: assert property (@(posedge clock)
        $rose(rstN) |-> (!wbCyc && (instrAddr == resetPc[`IMEM_AW+1:2])))
        else begin
            failCount++;
            $error("bad state right after reset");
        end

endmodule

/* tb_mipsCore.sv */
`timescale 1ns/1ps
`include "mips_config.svh"

module tb_mipsCore;

    localparam int memWords = 1024;
    localparam int timeoutCycles = 5000;
    localparam logic [31:0] resetPc = `RESET_PC;

    logic                clock = 1'b0;
    logic                rstN = 1'b0;
    logic [`IMEM_AW-1:0] instrAddr;
    logic [31:0]         instrData;
    logic                wbCyc;
    logic                wbStb;
    logic                wbWe;
    logic [`DMEM_AW-1:0] wbAdr;
    logic [31:0]         wbDatW;
    logic [31:0]         wbDatR = 32'd0;
    logic                wbAck = 1'b0;
    logic [3:0]          wbSel;

    logic [31:0] imem [memWords];
    logic [31:0] dmem [memWords];
    logic [31:0] expAdr [$];
    logic [31:0] expDat [$];
    logic [1:0]  waitCnt = 2'd0;

    mipsCore u_mipsCore (.*);

    bind mipsCore mipsCoreSva u_mipsCoreSva (
        .clock(clock), .rstN(rstN), .instrAddr(instrAddr), .wbCyc(wbCyc), .wbStb(wbStb),
        .wbWe(wbWe), .wbAdr(wbAdr), .wbDatW(wbDatW), .wbAck(wbAck)
    );

    always #2 clock = ~clock;   // 4 ns period

    assign instrData = imem[instrAddr];     // combinational fetch

    task automatic stopWithFailure(input string reason);
        $display("%s", reason);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
            stopWithFailure("value mismatch");
        end
    endtask

    task automatic loadProgramFile();
        int          fd;
        int          cnt;
        string       line;
        byte         kind;
        logic [31:0] addr;
        logic [31:0] data;
        fd = $fopen("program_input.txt", "r");
        if (fd == 0) begin
            stopWithFailure("could not open program_input.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            cnt = $fgets(line, fd);
            if (line.len() > 1 && line[0] != "#") begin
                cnt = $sscanf(line, "%c %h %h", kind, addr, data);
                if (cnt == 3) begin
                    case (kind)
                        "P": imem[addr] = data;
                        "L": dmem[addr] = data;
                        "S": begin
                            expAdr.push_back(addr);
                            expDat.push_back(data);
                        end
                        default: stopWithFailure("unknown line kind in program_input.txt");
                    endcase
                end
            end
        end
        $fclose(fd);
    endtask

    // bound assertions count their failures
    always @(u_mipsCore.u_mipsCoreSva.failCount) begin
        if (u_mipsCore.u_mipsCoreSva.failCount != 0) begin
            stopWithFailure("a bound assertion failed");
        end
    end

    // wishbone slave with 0 to 3 wait states
    always @(posedge clock) begin
        if (!rstN) begin
            wbAck <= 1'b0;
        end else if (wbCyc && wbStb && !wbAck) begin
            if (waitCnt == 2'd0) begin
                checkValue("wbSel", 32'(wbSel), 32'h0000_000F);   // word accesses only
                wbAck   <= 1'b1;
                waitCnt <= 2'($urandom % 4);
                if (wbWe) begin
                    if (expAdr.size() == 0) begin
                        stopWithFailure("store seen after the last expected one");
                    end
                    checkValue("wbAdr", 32'(wbAdr), expAdr[0]);
                    checkValue("wbDatW", wbDatW, expDat[0]);
                    void'(expAdr.pop_front());
                    void'(expDat.pop_front());
                    dmem[wbAdr] <= wbDatW;
                end else begin
                    wbDatR <= dmem[wbAdr];
                end
            end else begin
                waitCnt <= waitCnt - 2'd1;
            end
        end else begin
            wbAck <= 1'b0;
        end
    end

    initial begin
        int cycles;
        void'($urandom(32'h86c2_84f1));
        for (int i = 0; i < memWords; i++) begin
            imem[i] = 32'h0800_0000 | i;    // j to itself
            dmem[i] = 32'hD00D_0000 ^ (i * 32'h0001_0001);
        end
        loadProgramFile();
        waitCnt = 2'($urandom % 4);
        repeat (16) begin
            @(negedge clock);
            checkValue("instrAddr", 32'(instrAddr), 32'(resetPc[`IMEM_AW+1:2]));
            checkValue("wbCyc", 32'(wbCyc), 32'd0);
        end
        @(posedge clock);
        rstN <= 1'b1;
        @(negedge clock);
        checkValue("instrAddr", 32'(instrAddr), 32'(resetPc[`IMEM_AW+1:2]));
        cycles = 0;
        while (expAdr.size() != 0) begin
            @(posedge clock);
            cycles++;
            if (cycles > timeoutCycles) begin
                stopWithFailure("timeout waiting for the expected stores");
            end
        end
        repeat (4) @(posedge clock);
        $display("Everything OK");
        $finish;
    end

endmodule

/* program_input.txt */
# P word-index instruction | L word-index preload | S wbAdr data, in store order
# all values hex
P 000 2001FFF8
P 001 34028005
P 002 00221820
P 003 00412022
P 004 00222827
P 005 3826FFFF
P 006 00C23824
P 007 3C081234
P 008 30C98F0F
P 009 01095026
P 00A AC030100
P 00B AC040104
P 00C AC050108
P 00D AC07010C
P 00E AC0A0110
P 00F 3C0B8000
P 010 356B00F0
P 011 000B6103
P 012 000B6902
P 013 000B7100
P 014 002B8007
P 015 002B8806
P 016 002B9004
P 017 0022982A
P 018 0022A02B
P 019 AC0C0114
P 01A AC0D0118
P 01B AC0E011C
P 01C AC100120
P 01D AC110124
P 01E AC120128
P 01F AC13012C
P 020 AC140130
P 021 10210001
P 022 AC0201FC
P 023 14220001
P 024 AC0201FC
P 025 10220001
P 026 201800A1
P 027 AC180134
P 028 14210001
P 029 201800A2
P 02A AC180138
P 02B 0800002D
P 02C AC0201FC
P 02D 0C000030
P 02E AC1F013C
P 02F 08000034
P 030 201800A3
P 031 AC180140
P 032 03E00008
P 033 AC0201FC
P 034 8C190040
P 035 8C1A0044
P 036 033AD821
P 037 AC1B0144
P 038 033AE023
P 039 AC1C0148
P 03A 0800003A
L 010 13572468
L 011 00001111
S 040 00007FFD
S 041 0000800D
S 042 00000002
S 043 00000005
S 044 12340007
S 045 F800000F
S 046 0800000F
S 047 00000F00
S 048 FFFFFF80
S 049 00000080
S 04A F0000000
S 04B 00000001
S 04C 00000000
S 04D 000000A1
S 04E 000000A2
S 050 000000A3
S 04F 000000B8
S 051 13573579
S 052 13571357

/* files.f */
+incdir+.
mipsPkg.sv
execBus.sv
fetchUnit.sv
decodeUnit.sv
aluUnit.sv
memAccess.sv
mipsCore.sv
mipsCore_sva.sv
tb_mipsCore.sv

/* Bender.yml */
package:
  name: mips_core

sources:
  - include_dirs:
      - .
    files:
      - mipsPkg.sv
      - execBus.sv
      - fetchUnit.sv
      - decodeUnit.sv
      - aluUnit.sv
      - memAccess.sv
      - mipsCore.sv
  - target: test
    include_dirs:
      - .
    files:
      - mipsCore_sva.sv
      - tb_mipsCore.sv
